//--- logic/mm_dims_pkg.sv
/*
   dimension constants for the dot product datapath
   vector length, element, product, sum and tag widths
*/
package mm_dims_pkg;

   // one row or one column
   localparam int ROW_COL_SIZE  = 4;    // elements per vector
   localparam int OPERAND_WIDTH = 8;    // unsigned element

   // arithmetic widths
   localparam int PRODUCT_WIDTH = 16;   // 8 x 8 unsigned, full width
   // 4 products of at most 65025 each -> 260100 max, fits in 18 bits
   localparam int SUM_WIDTH     = 18;

   // item identification, returned with the sum
   localparam int TAG_WIDTH     = 4;

endpackage

//--- logic/mm_types_pkg.sv
/*
   packed structs carried through the dot product datapath
   operand pair from the sender, product set after the multiplier,
   result towards the consumer
*/
package mm_types_pkg;

   // one vector of unsigned elements, element 0 in the low bits
   typedef logic [mm_dims_pkg::ROW_COL_SIZE-1:0][mm_dims_pkg::OPERAND_WIDTH-1:0] operand_vec_t;

   // all pairwise products, same element order as the vectors
   typedef logic [mm_dims_pkg::ROW_COL_SIZE-1:0][mm_dims_pkg::PRODUCT_WIDTH-1:0] product_vec_t;

   typedef struct packed {
      logic [mm_dims_pkg::TAG_WIDTH-1:0] tag;   // echoed back on the result
      operand_vec_t                      row;
      operand_vec_t                      col;
   } operand_pair_t;

   // registered output of the multiplier stage
   typedef struct packed {
      logic [mm_dims_pkg::TAG_WIDTH-1:0] tag;
      product_vec_t                      product;  // flat layout as the adder expects
   } product_set_t;

   typedef struct packed {
      logic [mm_dims_pkg::TAG_WIDTH-1:0] tag;
      logic [mm_dims_pkg::SUM_WIDTH-1:0] sum;   // full dot product, no overflow
   } result_t;

endpackage

//--- logic/credit_fifo.sv
`timescale 1ns/10ps
/*
   FIFO with payload type parameter and occupancy count
   registered credit pulse returned for every pop
*/
module credit_fifo #(
   parameter int  DEPTH     = 4,
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     not_empty,
   output logic     credit
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];   // entry storage
   logic [PTR_W-1:0] wr_ptr;        // next slot to write
   logic [PTR_W-1:0] rd_ptr;        // current head slot
   logic [CNT_W-1:0] count;         // entries held
   logic             full;

   // pointer advance, wraps at DEPTH so any depth works
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      logic [PTR_W-1:0] nxt;
      if (ptr == PTR_W'(DEPTH - 1)) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   assign not_empty = (count != '0);
   assign full      = (count == CNT_W'(DEPTH));
   assign head      = mem[rd_ptr];   // first word fall through

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         credit <= pop;   // one pulse per freed slot, one cycle late
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or push and pop together
         endcase
      end
   end

   // the sender's credits must keep it from ever overrunning the buffer
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> !full)
      else $error("credit_fifo: push while full");

   // pop is only legal when the consumer side saw not_empty
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      pop |-> not_empty)
      else $error("credit_fifo: pop while empty");

endmodule

//--- logic/row_col_multiplier.sv
`timescale 1ns/10ps
/*
   issue logic towards the input FIFO and the egress reservation
   registered stage of pairwise element products with tag
*/
module row_col_multiplier (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        pair_ready,  // input FIFO not empty
   input  mm_types_pkg::operand_pair_t pair,        // FIFO head
   input  logic                        room,        // unreserved result slot left
   output logic                        issue,       // pop and reserve
   output logic                        prod_valid,
   output mm_types_pkg::product_set_t  prod
);
   import mm_dims_pkg::*;
   import mm_types_pkg::*;

   product_set_t prod_next;   // products of the current head

   // issue only with a reserved slot downstream, so the stage never stalls
   assign issue = pair_ready & room;

   // unsigned 8 x 8 multiplies, one per element
   always_comb begin
      prod_next.tag = pair.tag;
      for (int i = 0; i < ROW_COL_SIZE; i++) begin
         prod_next.product[i] = PRODUCT_WIDTH'(pair.row[i]) * PRODUCT_WIDTH'(pair.col[i]);
      end
   end

   // valid follows issue by one cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         prod_valid <= 1'b0;
      end else begin
         prod_valid <= issue;
      end
   end

   // payload register, only loaded on issue
   always_ff @(posedge clk) begin
      if (issue) begin
         prod <= prod_next;
      end
   end

endmodule

//--- logic/row_col_product_adder.sv
`timescale 1ns/10ps
/*
   combinational adder for the products of one row and one column
   ripple chain of partial sums, element 0 first
*/
module row_col_product_adder #(
   parameter int PRODUCT_WIDTH = 16,
   parameter int SUM_WIDTH     = 32,
   parameter int ROW_COL_SIZE  = 16
) (
   input  logic [ROW_COL_SIZE*PRODUCT_WIDTH-1:0] product,   // flat, element 0 in low bits
   output logic [SUM_WIDTH-1:0]                  sum
);

   // running total after each element
   logic [SUM_WIDTH-1:0] partial_sum [ROW_COL_SIZE];

   assign sum = partial_sum[ROW_COL_SIZE-1];   // last stage holds the full sum

   for (genvar i = 0; i < ROW_COL_SIZE; i++) begin : g_chain
      if (i == 0) begin : g_first
         // chain seed, zero extended product
         assign partial_sum[i] = SUM_WIDTH'(product[PRODUCT_WIDTH-1:0]);
      end else begin : g_next
         // previous total plus this element's product
         assign partial_sum[i] = partial_sum[i-1]
                               + SUM_WIDTH'(product[i*PRODUCT_WIDTH +: PRODUCT_WIDTH]);
      end
   end

endmodule

//--- logic/result_egress.sv
`timescale 1ns/10ps
/*
   output side of the dot product unit
   result buffer, result slot reservation counter,
   downstream credit counter and output pop
*/
module result_egress #(
   parameter int OUT_DEPTH   = 4,
   parameter int OUT_CREDITS = 2
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              issue,       // reserve one slot
   input  logic                              sum_valid,   // adder output valid
   input  logic [mm_dims_pkg::TAG_WIDTH-1:0] tag,
   input  logic [mm_dims_pkg::SUM_WIDTH-1:0] sum,
   output logic                              room,
   output logic                              out_valid,
   output mm_types_pkg::result_t             out_result,
   input  logic                              out_credit   // consumer returns one
);
   import mm_types_pkg::*;

   localparam int FREE_W = $clog2(OUT_DEPTH + 1);
   localparam int CRED_W = $clog2(OUT_CREDITS + 1);

   result_t           wr_result;      // tag and sum as written to the buffer
   logic              buf_not_empty;
   logic              pop;
   logic [FREE_W-1:0] free_slots;     // slots not yet reserved
   logic [CRED_W-1:0] cred_cnt;       // downstream credits held

   assign wr_result.tag = tag;
   assign wr_result.sum = sum;

   // result buffer, its own credit pulse has no consumer here
   credit_fifo #(
      .DEPTH     (OUT_DEPTH),
      .payload_t (result_t)
   ) u_result_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (sum_valid),
      .push_data (wr_result),
      .pop       (pop),
      .head      (out_result),
      .not_empty (buf_not_empty),
      .credit    ()
   );

   // send whenever a result waits and the consumer has space
   assign pop       = buf_not_empty && (cred_cnt != '0);
   assign out_valid = pop;
   assign room      = (free_slots != '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         free_slots <= FREE_W'(OUT_DEPTH);
         cred_cnt   <= CRED_W'(OUT_CREDITS);
      end else begin
         // slot taken at issue, given back when its result leaves
         case ({issue, pop})
            2'b10:   free_slots <= free_slots - 1'b1;
            2'b01:   free_slots <= free_slots + 1'b1;
            default: free_slots <= free_slots;
         endcase
         // one credit spent per result, returned by consumer pulses
         case ({pop, out_credit})
            2'b10:   cred_cnt <= cred_cnt - 1'b1;
            2'b01:   cred_cnt <= cred_cnt + 1'b1;
            default: cred_cnt <= cred_cnt;
         endcase
      end
   end

   // consumer may not return more credits than it granted
   a_cred_bound: assert property (@(posedge clk) disable iff (!rst_n)
      cred_cnt <= CRED_W'(OUT_CREDITS))
      else $error("result_egress: credit count above initial grant");

endmodule

//--- logic/dot_product_top.sv
`timescale 1ns/10ps
/*
   top level of the dot product unit
   input FIFO, multiplier stage, product adder and egress
*/
module dot_product_top #(
   parameter int IN_DEPTH    = 4,   // sender's initial credits
   parameter int OUT_DEPTH   = 4,
   parameter int OUT_CREDITS = 2
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        in_valid,
   input  mm_types_pkg::operand_pair_t in_pair,
   output logic                        in_credit,
   output logic                        out_valid,
   output mm_types_pkg::result_t       out_result,
   input  logic                        out_credit
);
   import mm_dims_pkg::*;
   import mm_types_pkg::*;

   operand_pair_t        pair_head;    // oldest waiting pair
   logic                 pair_ready;
   logic                 issue;        // pop plus slot reservation
   logic                 room;
   logic                 prod_valid;
   product_set_t         prod;
   logic [SUM_WIDTH-1:0] sum;          // combinational dot product

   credit_fifo #(
      .DEPTH     (IN_DEPTH),
      .payload_t (operand_pair_t)
   ) u_in_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (in_valid),
      .push_data (in_pair),
      .pop       (issue),
      .head      (pair_head),
      .not_empty (pair_ready),
      .credit    (in_credit)     // straight back to the sender
   );

   row_col_multiplier u_mult (
      .clk        (clk),
      .rst_n      (rst_n),
      .pair_ready (pair_ready),
      .pair       (pair_head),
      .room       (room),
      .issue      (issue),
      .prod_valid (prod_valid),
      .prod       (prod)
   );

   row_col_product_adder #(
      .PRODUCT_WIDTH (PRODUCT_WIDTH),
      .SUM_WIDTH     (SUM_WIDTH),
      .ROW_COL_SIZE  (ROW_COL_SIZE)
   ) u_adder (
      .product (prod.product),
      .sum     (sum)
   );

   result_egress #(
      .OUT_DEPTH   (OUT_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) u_egress (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue      (issue),
      .sum_valid  (prod_valid),   // sum settles in the same cycle
      .tag        (prod.tag),
      .sum        (sum),
      .room       (room),
      .out_valid  (out_valid),
      .out_result (out_result),
      .out_credit (out_credit)
   );

endmodule

//--- sim/tb_dot_product.sv
`timescale 1ns/10ps
/*
   testbench for the dot product unit
   sender and consumer credit models, software dot product reference,
   one task per test with a closing summary
*/
module tb_dot_product;
   import mm_dims_pkg::*;
   import mm_types_pkg::*;

   localparam int IN_DEPTH    = 4;
   localparam int OUT_DEPTH   = 4;
   localparam int OUT_CREDITS = 2;
   localparam int TIMEOUT     = 200;   // cycles allowed per wait

   logic          clk;
   logic          rst_n;
   logic          in_valid;
   operand_pair_t in_pair;
   logic          in_credit;
   logic          out_valid;
   result_t       out_result;
   logic          out_credit;

   result_t exp_q[$];         // tag and reference sum, in send order
   result_t last_result;      // most recent result taken by the consumer
   int      sender_credits;   // credits held by the sender
   int      owed_credits;     // results taken, credit not yet returned
   bit      returns_on;       // consumer gives credits back
   int      in_credit_seen;
   int      results_seen;
   int      errors;
   int      checks;
   int      tests_run;

   dot_product_top #(
      .IN_DEPTH    (IN_DEPTH),
      .OUT_DEPTH   (OUT_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_pair    (in_pair),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_result (out_result),
      .out_credit (out_credit)
   );

   always #20 clk = ~clk;   // 40 ns period

   // unsigned dot product, element by element
   function automatic logic [SUM_WIDTH-1:0] dot_ref(input operand_pair_t p);
      int acc;
      acc = 0;
      for (int i = 0; i < ROW_COL_SIZE; i++) begin
         acc += int'(p.row[i]) * int'(p.col[i]);
      end
      return SUM_WIDTH'(acc);
   endfunction

   function automatic operand_pair_t rand_pair(input logic [TAG_WIDTH-1:0] tag);
      operand_pair_t p;
      p.tag = tag;
      for (int i = 0; i < ROW_COL_SIZE; i++) begin
         p.row[i] = OPERAND_WIDTH'($urandom);
         p.col[i] = OPERAND_WIDTH'($urandom);
      end
      return p;
   endfunction

   // falling edge: sample outputs first, then default drives
   task automatic next_cycle();
      result_t want;
      @(negedge clk);
      if (in_credit) begin
         sender_credits++;
         in_credit_seen++;
      end
      checks++;
      assert (sender_credits <= IN_DEPTH) else begin
         $display("%0t: sender got back more input credits than it spent", $time);
         errors++;
      end
      if (out_valid) begin
         results_seen++;
         owed_credits++;
         last_result = out_result;
         checks++;
         assert (exp_q.size() > 0) else begin
            $display("%0t: result with tag %0h arrived while none was expected",
                     $time, out_result.tag);
            errors++;
         end
         if (exp_q.size() > 0) begin
            want = exp_q.pop_front();   // results must keep input order
            checks += 2;
            assert (out_result.tag == want.tag) else begin
               $display("[ERROR] %0t out_result.tag expected %0h got %0h",
                        $time, want.tag, out_result.tag);
               errors++;
            end
            assert (out_result.sum == want.sum) else begin
               $display("[ERROR] %0t out_result.sum expected %0d got %0d",
                        $time, want.sum, out_result.sum);
               errors++;
            end
         end
      end
      in_valid   = 1'b0;
      out_credit = 1'b0;
      if (returns_on && owed_credits > 0) begin
         out_credit = 1'b1;   // one return per cycle
         owed_credits--;
      end
   endtask

   // spends one sender credit, caller has checked it holds one
   task automatic drive_pair(input operand_pair_t p);
      result_t want;
      in_valid = 1'b1;
      in_pair  = p;
      sender_credits--;
      want.tag = p.tag;
      want.sum = dot_ref(p);
      exp_q.push_back(want);
   endtask

   task automatic send_pair(input operand_pair_t p);
      int n;
      n = 0;
      next_cycle();
      while (sender_credits == 0 && n < TIMEOUT) begin
         next_cycle();
         n++;
      end
      if (sender_credits == 0) begin
         $display("%0t: sender never got an input credit back", $time);
         errors++;
      end else begin
         drive_pair(p);
      end
   endtask

   // all results out, all credits home on both sides
   task automatic settle();
      int n;
      n = 0;
      while ((exp_q.size() > 0 || sender_credits != IN_DEPTH || owed_credits != 0)
             && n < TIMEOUT) begin
         next_cycle();
         n++;
      end
      checks++;
      assert (exp_q.size() == 0 && sender_credits == IN_DEPTH) else begin
         $display("%0t: unit did not drain, %0d results still missing", $time, exp_q.size());
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before) begin
         $display("%-22s ok", name);
      end else begin
         $display("%-22s FAIL, %0d error(s)", name, errors - err_before);
      end
   endtask

   task automatic reset_and_single();
      operand_pair_t p;
      int            e0;
      int            c0;
      e0 = errors;
      c0 = in_credit_seen;
      repeat (6) begin   // idle unit stays quiet
         next_cycle();
         checks += 2;
         assert (!out_valid) else begin
            $display("[ERROR] %0t out_valid expected 0 got %0b", $time, out_valid);
            errors++;
         end
         assert (!in_credit) else begin
            $display("[ERROR] %0t in_credit expected 0 got %0b", $time, in_credit);
            errors++;
         end
      end
      p.tag = 4'h3;
      for (int i = 0; i < ROW_COL_SIZE; i++) begin
         p.row[i] = OPERAND_WIDTH'(i + 1);   // 1 2 3 4
         p.col[i] = OPERAND_WIDTH'(i + 5);   // 5 6 7 8
      end
      send_pair(p);
      settle();
      checks += 2;
      assert (last_result.sum == SUM_WIDTH'(70)) else begin   // 5+12+21+32
         $display("[ERROR] %0t out_result.sum expected 70 got %0d", $time, last_result.sum);
         errors++;
      end
      assert (in_credit_seen - c0 == 1) else begin
         $display("%0t: expected one input credit for one item, saw %0d",
                  $time, in_credit_seen - c0);
         errors++;
      end
      report_test("reset_and_single", e0);
   endtask

   task automatic random_stream();
      int e0;
      int r0;
      e0 = errors;
      r0 = results_seen;
      for (int i = 0; i < 16; i++) begin
         send_pair(rand_pair(TAG_WIDTH'(i)));
      end
      settle();
      checks++;
      assert (results_seen - r0 == 16) else begin
         $display("%0t: 16 items sent but %0d results seen", $time, results_seen - r0);
         errors++;
      end
      report_test("random_stream", e0);
   endtask

   task automatic all_ones();
      operand_pair_t p;
      int            e0;
      e0 = errors;
      p.tag = 4'hf;
      for (int i = 0; i < ROW_COL_SIZE; i++) begin
         p.row[i] = '1;
         p.col[i] = '1;
      end
      send_pair(p);
      settle();
      checks++;
      assert (last_result.sum == SUM_WIDTH'(260100)) else begin   // 4 x 255 x 255
         $display("[ERROR] %0t out_result.sum expected 260100 got %0d",
                  $time, last_result.sum);
         errors++;
      end
      report_test("all_ones", e0);
   endtask

   task automatic out_backpressure();
      int e0;
      int r0;
      e0 = errors;
      r0 = results_seen;
      returns_on = 1'b0;   // consumer holds its credits
      for (int i = 0; i < 4; i++) begin
         send_pair(rand_pair(TAG_WIDTH'(8 + i)));
      end
      repeat (40) begin    // watch window, nothing beyond the grant
         next_cycle();
      end
      checks++;
      assert (results_seen - r0 == OUT_CREDITS) else begin
         $display("[ERROR] %0t out_valid pulses expected %0d got %0d",
                  $time, OUT_CREDITS, results_seen - r0);
         errors++;
      end
      returns_on = 1'b1;
      settle();
      report_test("out_backpressure", e0);
   endtask

   task automatic in_credit_accounting();
      int e0;
      int c0;
      int sent;
      e0   = errors;
      c0   = in_credit_seen;
      sent = 0;
      returns_on = 1'b0;
      repeat (60) begin   // offer 14 items with the output stalled
         next_cycle();
         if (sent < 14 && sender_credits > 0) begin
            drive_pair(rand_pair(TAG_WIDTH'(sent)));
            sent++;
         end
      end
      checks += 2;
      assert (sender_credits == 0) else begin
         $display("%0t: sender still holds %0d credits with the output stalled",
                  $time, sender_credits);
         errors++;
      end
      // input FIFO, reserved buffer slots and the granted out credits
      assert (sent == IN_DEPTH + OUT_DEPTH + OUT_CREDITS) else begin
         $display("[ERROR] %0t items accepted expected %0d got %0d",
                  $time, IN_DEPTH + OUT_DEPTH + OUT_CREDITS, sent);
         errors++;
      end
      returns_on = 1'b1;
      while (sent < 14) begin
         send_pair(rand_pair(TAG_WIDTH'(sent)));
         sent++;
      end
      settle();
      checks++;
      assert (in_credit_seen - c0 == sent) else begin
         $display("[ERROR] %0t in_credit pulses expected %0d got %0d",
                  $time, sent, in_credit_seen - c0);
         errors++;
      end
      report_test("in_credit_accounting", e0);
   endtask

   initial begin
      clk            = 1'b0;
      rst_n          = 1'b0;
      in_valid       = 1'b0;
      in_pair        = '0;
      out_credit     = 1'b0;
      sender_credits = IN_DEPTH;
      owed_credits   = 0;
      returns_on     = 1'b1;
      in_credit_seen = 0;
      results_seen   = 0;
      errors         = 0;
      checks         = 0;
      tests_run      = 0;
      void'($urandom(32'h1050));   // single seed for the run
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      reset_and_single();
      random_stream();
      all_ones();
      out_backpressure();
      in_credit_accounting();
      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- list.f
logic/mm_dims_pkg.sv
logic/mm_types_pkg.sv
logic/credit_fifo.sv
logic/row_col_multiplier.sv
logic/row_col_product_adder.sv
logic/result_egress.sv
logic/dot_product_top.sv
sim/tb_dot_product.sv

//--- Makefile
# Verilator flow for the dot product unit

VERILATOR  ?= verilator
TOP        := tb_dot_product
FILELIST   := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := test passed
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
